//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the dvi pixel path testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
   --timescale 1ns/10ps \
   --top-module dvi_tb \
   -f sim.f \
   -o dvi_sim 2>&1 | tee build.log

./obj_dir/dvi_sim 2>&1 | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi

//--- sim.f
src/dvi_pkg.sv
src/video_timing.sv
src/pixel_fetch.sv
src/dvi_output.sv
src/dvi_top.sv
tb/dvi_checker.sv
tb/dvi_tb.sv

//--- src/dvi_output.sv
`timescale 1ns/10ps
`default_nettype none

module dvi_output (
   input  logic                       clk_25mhz,
   input  logic                       rst_n,
   input  dvi_pkg::timing_t           timing,
   input  dvi_pkg::pixel_t            pixel,
   output logic [dvi_pkg::HALF_W-1:0] d,
   output logic                       hsync,
   output logic                       vsync,
   output logic                       blank
);
   import dvi_pkg::*;

   timing_t           timing_q;
   logic [PIX_W-1:0]  held_q;
   logic [PIX_W-1:0]  cur_data;
   logic [HALF_W-1:0] half;

   ////////////////////////////////////////
   // alignment stage
   ////////////////////////////////////////

   // first of two timing stages
   // lines up with the pixel word from the fetch side
   always_ff @(posedge clk_25mhz or negedge rst_n) begin
      if (!rst_n) begin
         timing_q <= TIMING_IDLE;
      end else begin
         timing_q <= timing;
      end
   end

   // keep the last word for its low half
   always_ff @(posedge clk_25mhz) begin
      if (pixel.valid) begin
         held_q <= pixel.data;
      end
   end

   // fresh word bypasses the hold register in its first cycle
   assign cur_data = pixel.valid ? pixel.data : held_q;

   // high half first, then low half
   assign half = (timing_q.phase == PH_HIGH) ? cur_data[PIX_W-1 -: HALF_W]
                                             : cur_data[HALF_W-1:0];

   ////////////////////////////////////////
   // pin registers
   ////////////////////////////////////////

   // second stage, pins lag the raster by two cycles
   always_ff @(posedge clk_25mhz or negedge rst_n) begin
      if (!rst_n) begin
         d     <= '0;
         hsync <= 1'b1;
         vsync <= 1'b1;
         blank <= 1'b1;
      end else begin
         // data bus held at zero during blanking
         d     <= timing_q.blank ? '0 : half;
         hsync <= timing_q.hsync;
         vsync <= timing_q.vsync;
         blank <= timing_q.blank;
      end
   end

endmodule

`default_nettype wire

//--- src/dvi_pkg.sv
`default_nettype none

package dvi_pkg;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////

   // display plane address into the external rom
   localparam int ADDR_W = 13;
   // one rom word is one 24-bit pixel
   localparam int PIX_W  = 24;
   // encoder data bus carries half a pixel per cycle
   localparam int HALF_W = 12;
   // raster counters, pixels per line and lines per frame
   localparam int CNT_W  = 11;

   ////////////////////////////////////////
   // enums
   ////////////////////////////////////////

   // two clock cycles per pixel, high half goes first
   typedef enum logic {
      PH_HIGH,
      PH_LOW
   } phase_e;

   // horizontal raster regions, in line order
   typedef enum logic [1:0] {
      HS_ACTIVE,
      HS_FRONT,
      HS_SYNC,
      HS_BACK
   } hstate_e;

   // vertical raster regions, in frame order
   typedef enum logic [1:0] {
      VS_ACTIVE,
      VS_FRONT,
      VS_SYNC,
      VS_BACK
   } vstate_e;

   ////////////////////////////////////////
   // structs
   ////////////////////////////////////////

   // syncs active low, blank active high
   typedef struct packed {
      logic   hsync;
      logic   vsync;
      logic   blank;
      phase_e phase;
   } timing_t;

   // captured rom word, valid pulses once per pixel
   typedef struct packed {
      logic             valid;
      logic [PIX_W-1:0] data;
   } pixel_t;

   // idle raster, both syncs inactive and blanked
   localparam timing_t TIMING_IDLE = '{hsync: 1'b1, vsync: 1'b1, blank: 1'b1, phase: PH_HIGH};

endpackage

`default_nettype wire

//--- src/dvi_top.sv
`timescale 1ns/10ps
`default_nettype none

module dvi_top #(
   // horizontal values in pixels
   parameter int H_ACTIVE = 96,
   parameter int H_FRONT  = 8,
   parameter int H_SYNC   = 12,
   parameter int H_BACK   = 12,
   // vertical values in lines
   parameter int V_ACTIVE = 64,
   parameter int V_FRONT  = 3,
   parameter int V_SYNC   = 2,
   parameter int V_BACK   = 4
) (
   input  logic                        clk_25mhz,
   input  logic                        rst_n,
   // external display plane rom
   input  logic [dvi_pkg::PIX_W-1:0]   rom_out,
   output logic [dvi_pkg::ADDR_W-1:0]  display_plane_addr,
   // encoder chip pins
   output logic [dvi_pkg::HALF_W-1:0]  d,
   output logic                        hsync,
   output logic                        vsync,
   output logic                        blank
);
   import dvi_pkg::*;

   timing_t timing;
   pixel_t  pixel;
   logic    pix_req;
   logic    frame_start;

   ////////////////////////////////////////
   // raster and requests
   ////////////////////////////////////////

   video_timing #(
      .H_ACTIVE (H_ACTIVE),
      .H_FRONT  (H_FRONT),
      .H_SYNC   (H_SYNC),
      .H_BACK   (H_BACK),
      .V_ACTIVE (V_ACTIVE),
      .V_FRONT  (V_FRONT),
      .V_SYNC   (V_SYNC),
      .V_BACK   (V_BACK)
   ) i_video_timing (
      .clk_25mhz   (clk_25mhz),
      .rst_n       (rst_n),
      .timing      (timing),
      .pix_req     (pix_req),
      .frame_start (frame_start)
   );

   // rom address walk and word capture
   pixel_fetch i_pixel_fetch (
      .clk_25mhz          (clk_25mhz),
      .rst_n              (rst_n),
      .pix_req            (pix_req),
      .frame_start        (frame_start),
      .rom_out            (rom_out),
      .display_plane_addr (display_plane_addr),
      .pixel              (pixel)
   );

   // half select and pin registers
   dvi_output i_dvi_output (
      .clk_25mhz (clk_25mhz),
      .rst_n     (rst_n),
      .timing    (timing),
      .pixel     (pixel),
      .d         (d),
      .hsync     (hsync),
      .vsync     (vsync),
      .blank     (blank)
   );

endmodule

`default_nettype wire

//--- src/pixel_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_fetch (
   input  logic                      clk_25mhz,
   input  logic                      rst_n,
   input  logic                      pix_req,
   input  logic                      frame_start,
   input  logic [dvi_pkg::PIX_W-1:0] rom_out,
   output logic [dvi_pkg::ADDR_W-1:0] display_plane_addr,
   output dvi_pkg::pixel_t            pixel
);
   import dvi_pkg::*;

   logic [ADDR_W-1:0] addr_q;
   logic [PIX_W-1:0]  data_q;
   logic              valid_q;

   ////////////////////////////////////////
   // plane address
   ////////////////////////////////////////

   // address moves only on the two strobes
   // word for the next pixel is presented from the low half onward
   always_ff @(posedge clk_25mhz or negedge rst_n) begin
      if (!rst_n) begin
         addr_q  <= '0;
         valid_q <= 1'b0;
      end else begin
         valid_q <= pix_req;
         if (frame_start) begin
            addr_q <= '0;
         end else if (pix_req) begin
            addr_q <= addr_q + 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // rom word capture
   ////////////////////////////////////////

   // rom answers one cycle late
   // by the request cycle the word matches the current address
   always_ff @(posedge clk_25mhz) begin
      if (pix_req) begin
         data_q <= rom_out;
      end
   end

   assign display_plane_addr = addr_q;

   // valid in the low half of the same pixel
   assign pixel.valid = valid_q;
   assign pixel.data  = data_q;

endmodule

`default_nettype wire

//--- src/video_timing.sv
`timescale 1ns/10ps
`default_nettype none

module video_timing #(
   parameter int H_ACTIVE = 96,
   parameter int H_FRONT  = 8,
   parameter int H_SYNC   = 12,
   parameter int H_BACK   = 12,
   parameter int V_ACTIVE = 64,
   parameter int V_FRONT  = 3,
   parameter int V_SYNC   = 2,
   parameter int V_BACK   = 4
) (
   input  logic             clk_25mhz,
   input  logic             rst_n,
   output dvi_pkg::timing_t timing,
   output logic             pix_req,
   output logic             frame_start
);
   import dvi_pkg::*;

   ////////////////////////////////////////
   // region boundaries
   ////////////////////////////////////////

   // first pixel of each horizontal region
   localparam logic [CNT_W-1:0] H_FP_START = CNT_W'(H_ACTIVE);
   localparam logic [CNT_W-1:0] H_SY_START = CNT_W'(H_ACTIVE + H_FRONT);
   localparam logic [CNT_W-1:0] H_BP_START = CNT_W'(H_ACTIVE + H_FRONT + H_SYNC);
   localparam logic [CNT_W-1:0] H_LAST     = CNT_W'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);

   // first line of each vertical region
   localparam logic [CNT_W-1:0] V_FP_START = CNT_W'(V_ACTIVE);
   localparam logic [CNT_W-1:0] V_SY_START = CNT_W'(V_ACTIVE + V_FRONT);
   localparam logic [CNT_W-1:0] V_BP_START = CNT_W'(V_ACTIVE + V_FRONT + V_SYNC);
   localparam logic [CNT_W-1:0] V_LAST     = CNT_W'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

   phase_e           phase_q;
   logic [CNT_W-1:0] h_cnt;
   logic [CNT_W-1:0] v_cnt;
   logic [CNT_W-1:0] h_next;
   logic [CNT_W-1:0] v_next;
   hstate_e          hstate;
   hstate_e          hstate_next;
   vstate_e          vstate;
   vstate_e          vstate_next;
   logic             pix_end;
   logic             line_end;

   // pixel ends after its low half
   assign pix_end  = (phase_q == PH_LOW);
   assign line_end = pix_end && (h_cnt == H_LAST);

   // wrap at the end of line and frame
   assign h_next = (h_cnt == H_LAST) ? '0 : h_cnt + 1'b1;
   assign v_next = (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;

   ////////////////////////////////////////
   // region fsms
   ////////////////////////////////////////

   // later boundary wins, so a zero length region is skipped
   always_comb begin
      hstate_next = hstate;
      if (h_next == H_BP_START) begin
         hstate_next = HS_BACK;
      end else if (h_next == H_SY_START) begin
         hstate_next = HS_SYNC;
      end else if (h_next == H_FP_START) begin
         hstate_next = HS_FRONT;
      end else if (h_next == '0) begin
         hstate_next = HS_ACTIVE;
      end
   end

   always_comb begin
      vstate_next = vstate;
      if (v_next == V_BP_START) begin
         vstate_next = VS_BACK;
      end else if (v_next == V_SY_START) begin
         vstate_next = VS_SYNC;
      end else if (v_next == V_FP_START) begin
         vstate_next = VS_FRONT;
      end else if (v_next == '0) begin
         vstate_next = VS_ACTIVE;
      end
   end

   // phase every cycle, pixel counter per pixel, line counter per line
   always_ff @(posedge clk_25mhz or negedge rst_n) begin
      if (!rst_n) begin
         phase_q <= PH_HIGH;
         h_cnt   <= '0;
         v_cnt   <= '0;
         hstate  <= HS_ACTIVE;
         vstate  <= VS_ACTIVE;
      end else begin
         phase_q <= (phase_q == PH_HIGH) ? PH_LOW : PH_HIGH;
         if (pix_end) begin
            h_cnt  <= h_next;
            hstate <= hstate_next;
         end
         if (line_end) begin
            v_cnt  <= v_next;
            vstate <= vstate_next;
         end
      end
   end

   ////////////////////////////////////////
   // registered outputs
   ////////////////////////////////////////

   // outputs show the counter position one cycle later
   always_ff @(posedge clk_25mhz or negedge rst_n) begin
      if (!rst_n) begin
         timing      <= TIMING_IDLE;
         pix_req     <= 1'b0;
         frame_start <= 1'b0;
      end else begin
         timing.hsync <= (hstate != HS_SYNC);
         timing.vsync <= (vstate != VS_SYNC);
         timing.blank <= (hstate != HS_ACTIVE) || (vstate != VS_ACTIVE);
         timing.phase <= phase_q;
         // one request per active pixel, in its high half
         pix_req      <= (hstate == HS_ACTIVE) && (vstate == VS_ACTIVE) && (phase_q == PH_HIGH);
         // rewind one line ahead of line 0 so word 0 is out of the rom in time
         // needs at least one vertical blanking line
         frame_start  <= (v_cnt == V_LAST) && (h_cnt == '0) && (phase_q == PH_HIGH);
      end
   end

endmodule

`default_nettype wire

//--- tb/dvi_checker.sv
`timescale 1ns/10ps
`default_nettype none

module dvi_checker #(
   parameter int H_ACTIVE = 96,
   parameter int H_FRONT  = 8,
   parameter int H_SYNC   = 12,
   parameter int H_BACK   = 12,
   parameter int V_ACTIVE = 64,
   parameter int V_FRONT  = 3,
   parameter int V_SYNC   = 2,
   parameter int V_BACK   = 4
) (
   input logic                        clk_25mhz,
   input logic                        rst_n,
   input logic [dvi_pkg::HALF_W-1:0]  d,
   input logic                        hsync,
   input logic                        vsync,
   input logic                        blank,
   input logic [dvi_pkg::ADDR_W-1:0]  display_plane_addr
);
   import dvi_pkg::*;

   // two cycles per pixel
   localparam int LINE_CYC  = 2 * (H_ACTIVE + H_FRONT + H_SYNC + H_BACK);
   localparam int FRAME_CYC = LINE_CYC * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
   localparam logic [ADDR_W-1:0] PLANE_WORDS = ADDR_W'(H_ACTIVE * V_ACTIVE);

   ////////////////////////////////////////
   // reset and blanking
   ////////////////////////////////////////

   // pins idle while reset is held
   a_reset_idle: assert property (@(posedge clk_25mhz)
      !rst_n |-> hsync && vsync && blank && d == '0 && display_plane_addr == '0)
      else $error("pins not idle during reset");

   // data bus quiet while blanked
   a_blank_d: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
      blank |-> d == '0)
      else $error("d not zero while blank is high");

   // one active stretch is 2*H_ACTIVE cycles
   a_blank_width: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
      $fell(blank) |-> ##(2 * H_ACTIVE) blank)
      else $error("blank low for the wrong number of cycles");

   // address never runs past the plane
   a_addr_range: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
      display_plane_addr <= PLANE_WORDS)
      else $error("display plane address out of range");

   ////////////////////////////////////////
   // sync pulses
   ////////////////////////////////////////

   a_hsync_low: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
      $fell(hsync) |-> ##(2 * H_SYNC - 1) !hsync)
      else $error("hsync pulse too short");

   a_hsync_end: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
      $fell(hsync) |-> ##(2 * H_SYNC) hsync)
      else $error("hsync pulse too long");

   // next line starts exactly one line period later
   a_line_period: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
      $fell(hsync) |-> ##(LINE_CYC) $fell(hsync))
      else $error("hsync period is not one line");

   a_vsync_end: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
      $fell(vsync) |-> ##(V_SYNC * LINE_CYC) vsync)
      else $error("vsync pulse is not V_SYNC lines");

   a_frame_period: assert property (@(posedge clk_25mhz) disable iff (!rst_n)
      $fell(vsync) |-> ##(FRAME_CYC) $fell(vsync))
      else $error("vsync period is not one frame");

endmodule

`default_nettype wire

//--- tb/dvi_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dvi_tb;
   import dvi_pkg::*;

   // small raster, pixels and lines
   localparam int H_ACTIVE  = 8;
   localparam int H_FRONT   = 2;
   localparam int H_SYNC    = 3;
   localparam int H_BACK    = 2;
   localparam int V_ACTIVE  = 4;
   localparam int V_FRONT   = 1;
   localparam int V_SYNC    = 2;
   localparam int V_BACK    = 1;
   localparam int H_TOTAL   = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL   = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
   localparam int LINE_CYC  = 2 * H_TOTAL;
   localparam int FRAME_CYC = LINE_CYC * V_TOTAL;
   localparam int FRAMES    = 3;
   // pins trail the raster by two cycles
   localparam int RUN_CYC   = FRAMES * FRAME_CYC + 2;
   localparam int PERIOD    = 40;

   // one cycle of expected pin values
   typedef struct packed {
      logic [HALF_W-1:0] d;
      logic              hsync;
      logic              vsync;
      logic              blank;
      logic [ADDR_W-1:0] addr;
   } pins_t;

   logic              clk_25mhz;
   logic              rst_n;
   logic [PIX_W-1:0]  rom_out;
   logic [ADDR_W-1:0] display_plane_addr;
   logic [HALF_W-1:0] d;
   logic              hsync;
   logic              vsync;
   logic              blank;

   logic [PIX_W-1:0]  rom [1 << ADDR_W];
   logic [ADDR_W-1:0] rom_addr_q;
   logic [HALF_W-1:0] frame_d [FRAMES][FRAME_CYC];
   integer            seed;
   int                errors [1:6];
   int                n_edges;
   int                hs_low;
   int                hs_fall;
   int                hs_pulses;
   int                vs_low;
   int                vs_fall;
   int                vs_pulses;
   int                bl_low;
   int                bl_runs;
   int                active_cyc;
   logic              prev_hs;
   logic              prev_vs;
   logic              prev_bl;
   logic              done;

   dvi_top #(
      .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
      .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
   ) i_dut (
      .clk_25mhz          (clk_25mhz),
      .rst_n              (rst_n),
      .rom_out            (rom_out),
      .display_plane_addr (display_plane_addr),
      .d                  (d),
      .hsync              (hsync),
      .vsync              (vsync),
      .blank              (blank)
   );

   bind dvi_top dvi_checker #(
      .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
      .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
   ) i_dvi_checker (
      .clk_25mhz          (clk_25mhz),
      .rst_n              (rst_n),
      .d                  (d),
      .hsync              (hsync),
      .vsync              (vsync),
      .blank              (blank),
      .display_plane_addr (display_plane_addr)
   );

   initial begin
      clk_25mhz = 1'b0;
      forever #(PERIOD / 2) clk_25mhz = ~clk_25mhz;
   end

   ////////////////////////////////////////
   // rom model and cycle count
   ////////////////////////////////////////

   // address taken mid cycle, word out one edge later
   always @(negedge clk_25mhz) begin
      rom_addr_q = display_plane_addr;
   end

   always @(posedge clk_25mhz) begin
      #2;
      rom_out = rom[rom_addr_q];
   end

   // edges since reset release
   always @(posedge clk_25mhz) begin
      if (rst_n) begin
         n_edges++;
      end
   end

   ////////////////////////////////////////
   // reference and helpers
   ////////////////////////////////////////

   // expected pins after edge e, where edge 0 is the first one out of reset
   function automatic pins_t expected_pins(input int e);
      pins_t            res;
      int               p;
      int               col;
      int               line;
      logic [PIX_W-1:0] word;
      res = '{d: '0, hsync: 1'b1, vsync: 1'b1, blank: 1'b1, addr: '0};
      if (e >= 2) begin
         p        = e - 2;
         col      = (p / 2) % H_TOTAL;
         line     = (p / LINE_CYC) % V_TOTAL;
         res.hsync = !(col >= H_ACTIVE + H_FRONT && col < H_ACTIVE + H_FRONT + H_SYNC);
         res.vsync = !(line >= V_ACTIVE + V_FRONT && line < V_ACTIVE + V_FRONT + V_SYNC);
         res.blank = !(col < H_ACTIVE && line < V_ACTIVE);
         if (!res.blank) begin
            word  = rom[line * H_ACTIVE + col];
            // high half in the first cycle of the pixel
            res.d = (p % 2 == 0) ? word[PIX_W-1 -: HALF_W] : word[HALF_W-1:0];
         end
      end
      // address counts requests one cycle back, rewound in the last blank line
      if (e >= 1) begin
         col  = ((e - 1) / 2) % H_TOTAL;
         line = ((e - 1) / LINE_CYC) % V_TOTAL;
         if (line == V_TOTAL - 1) begin
            res.addr = '0;
         end else if (line >= V_ACTIVE) begin
            res.addr = ADDR_W'(V_ACTIVE * H_ACTIVE);
         end else if (col >= H_ACTIVE) begin
            res.addr = ADDR_W'(line * H_ACTIVE + H_ACTIVE);
         end else begin
            res.addr = ADDR_W'(line * H_ACTIVE + col + 1);
         end
      end
      return res;
   endfunction

   // first two edges still show the reset values
   function automatic int owner_test(input int e, input int t);
      return (e < 2) ? 1 : t;
   endfunction

   task automatic check_value(input int t, input string name,
                              input logic [31:0] got, input logic [31:0] want);
      if (got !== want) begin
         $display("Mismatch at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, want, got);
         errors[t]++;
      end
   endtask

   task automatic expect_count(input int t, input string name, input int got, input int want);
      if (got < want) begin
         $display("too few %s seen: %0d of %0d", name, got, want);
         errors[t]++;
      end
   endtask

   task automatic report_test(input int t, input string name);
      $display("test %0d %s: %s, %0d errors", t, name, (errors[t] == 0) ? "pass" : "fail",
               errors[t]);
   endtask

   // later frames must repeat the first one
   task automatic compare_frames();
      for (int f = 1; f < FRAMES; f++) begin
         for (int i = 0; i < FRAME_CYC; i++) begin
            if (frame_d[f][i] !== frame_d[0][i]) begin
               $display("Mismatch at %0d ns: d in frame %0d cycle %0d expected 0x%0h, got 0x%0h",
                        $time, f, i, frame_d[0][i], frame_d[f][i]);
               errors[6]++;
            end
         end
      end
   endtask

   ////////////////////////////////////////
   // per cycle compare
   ////////////////////////////////////////

   always @(negedge clk_25mhz) begin : compare_pins
      pins_t want;
      int    e;
      if (rst_n && !done) begin
         e    = n_edges - 1;
         want = expected_pins(e);
         check_value(owner_test(e, 4), "d", 32'(d), 32'(want.d));
         check_value(owner_test(e, 2), "hsync", 32'(hsync), 32'(want.hsync));
         check_value(owner_test(e, 3), "vsync", 32'(vsync), 32'(want.vsync));
         check_value(owner_test(e, 5), "blank", 32'(blank), 32'(want.blank));
         check_value(owner_test(e, 6), "display_plane_addr", 32'(display_plane_addr),
                     32'(want.addr));
         if (blank) begin
            check_value(5, "d while blanked", 32'(d), 0);
         end
         // active cycles shown at the pins
         if (!blank) begin
            active_cyc++;
         end
         // hsync width and line period
         if (!hsync) hs_low++;
         if (prev_hs && !hsync) begin
            if (hs_fall >= 0) check_value(2, "hsync period", e - hs_fall, LINE_CYC);
            hs_fall = e;
         end
         if (!prev_hs && hsync) begin
            check_value(2, "hsync low cycles", hs_low, 2 * H_SYNC);
            hs_pulses++;
            hs_low = 0;
         end
         // vsync width and frame period
         if (!vsync) vs_low++;
         if (prev_vs && !vsync) begin
            if (vs_fall >= 0) check_value(3, "vsync period", e - vs_fall, FRAME_CYC);
            vs_fall = e;
         end
         if (!prev_vs && vsync) begin
            check_value(3, "vsync low cycles", vs_low, V_SYNC * LINE_CYC);
            vs_pulses++;
            vs_low = 0;
         end
         // active stretch per line
         if (!blank) bl_low++;
         if (!prev_bl && blank) begin
            check_value(5, "blank low cycles", bl_low, 2 * H_ACTIVE);
            bl_runs++;
            bl_low = 0;
         end
         if (e >= 2 && e - 2 < FRAMES * FRAME_CYC) begin
            frame_d[(e - 2) / FRAME_CYC][(e - 2) % FRAME_CYC] = d;
         end
         prev_hs = hsync;
         prev_vs = vsync;
         prev_bl = blank;
      end
   end

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////

   initial begin
      int total;
      int failed;
      rst_n      = 1'b1;
      rom_out    = '0;
      rom_addr_q = '0;
      done       = 1'b0;
      n_edges    = 0;
      hs_low     = 0;
      hs_fall    = -1;
      hs_pulses  = 0;
      vs_low     = 0;
      vs_fall    = -1;
      vs_pulses  = 0;
      bl_low     = 0;
      bl_runs    = 0;
      active_cyc = 0;
      prev_hs    = 1'b1;
      prev_vs    = 1'b1;
      prev_bl    = 1'b1;
      foreach (errors[i]) errors[i] = 0;
      seed = 32'hdcce_82f6;
      for (int i = 0; i < (1 << ADDR_W); i++) begin
         rom[i] = PIX_W'($random(seed));
      end
      // falling edge starts the async reset
      #1 rst_n = 1'b0;
      repeat (2) @(posedge clk_25mhz);
      @(negedge clk_25mhz);
      check_value(1, "hsync", 32'(hsync), 1);
      check_value(1, "vsync", 32'(vsync), 1);
      check_value(1, "blank", 32'(blank), 1);
      check_value(1, "d", 32'(d), 0);
      check_value(1, "display_plane_addr", 32'(display_plane_addr), 0);
      @(posedge clk_25mhz);
      #2 rst_n = 1'b1;
      wait (n_edges >= 3);
      @(negedge clk_25mhz);
      #1;
      report_test(1, "reset values");
      // three whole frames at the pins
      wait (n_edges >= RUN_CYC);
      @(negedge clk_25mhz);
      #1;
      done = 1'b1;
      expect_count(2, "hsync pulses", hs_pulses, FRAMES * V_TOTAL);
      report_test(2, "line timing");
      expect_count(3, "vsync pulses", vs_pulses, FRAMES);
      report_test(3, "frame timing");
      expect_count(4, "active cycles", active_cyc, FRAMES * V_ACTIVE * 2 * H_ACTIVE);
      report_test(4, "pixel data");
      expect_count(5, "active stretches", bl_runs, FRAMES * V_ACTIVE);
      report_test(5, "blanking");
      compare_frames();
      report_test(6, "frame wrap");
      total  = 0;
      failed = 0;
      for (int t = 1; t <= 6; t++) begin
         total += errors[t];
         if (errors[t] != 0) failed++;
      end
      $display("summary: %0d tests, %0d passed, %0d failed, %0d errors", 6, 6 - failed, failed,
               total);
      if (total == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // reset, three frames and half a frame of margin
   initial begin
      #((3 + RUN_CYC + FRAME_CYC / 2) * PERIOD);
      $display("watchdog: run did not finish within %0d cycles", 3 + RUN_CYC + FRAME_CYC / 2);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire
